// File: int_core_defs.svh
`ifndef INT_CORE_DEFS_SVH
`define INT_CORE_DEFS_SVH

// datapath width
`define XLEN 32

// physical register file
`define PHYS_REGS 64
`define PHYS_IDX 6

// reorder buffer tag width
`define ROB_IDX 5

// reservation station geometry
`define RS_DEPTH 8
`define RS_IDX 3

// result buses: 0 is the alu, 1 is the external unit
`define CDB_WIDTH 2

`endif

// File: int_core_pkg.sv
`include "int_core_defs.svh"

package int_core_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    typedef logic [`XLEN-1:0]     word_t;
    typedef logic [`PHYS_IDX-1:0] phys_reg_t;
    typedef logic [`ROB_IDX-1:0]  rob_id_t;
    typedef logic [`RS_IDX-1:0]   rs_idx_t;

    //////////////////////////////
    // operand selectors
    //////////////////////////////

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2  = 2'd0,
        OP2_IMM  = 2'd1,
        OP2_ZERO = 2'd2
    } op2_sel_t;

    // alu function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

endpackage

// File: int_core_if.sv
// renamed micro-op entering the station
interface dispatch_if;
    import int_core_pkg::*;

    logic      valid;
    logic      ready;
    rob_id_t   rob_id;
    phys_reg_t rd_phy;
    phys_reg_t rs1_phy;
    logic      rs1_valid;
    phys_reg_t rs2_phy;
    logic      rs2_valid;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    alu_op_t   alu_op;
    word_t     imm;
    word_t     pc;

    modport rs (
        input  valid, rob_id, rd_phy, rs1_phy, rs1_valid, rs2_phy, rs2_valid,
        input  op1_sel, op2_sel, alu_op, imm, pc,
        output ready
    );
endinterface

// operand read, values come back in the same cycle
interface prf_read_if;
    import int_core_pkg::*;

    phys_reg_t rs1_phy;
    phys_reg_t rs2_phy;
    word_t     rs1_value;
    word_t     rs2_value;

    modport rs  (output rs1_phy, rs2_phy, input rs1_value, rs2_value);
    modport prf (input rs1_phy, rs2_phy, output rs1_value, rs2_value);
endinterface

// result broadcast, valid only, never stalled
interface cdb_if;
    import int_core_pkg::*;

    logic      valid;
    rob_id_t   rob_id;
    phys_reg_t rd_phy;
    word_t     value;

    modport drive  (output valid, rob_id, rd_phy, value);
    modport listen (input valid, rob_id, rd_phy, value);
endinterface

// issue register to alu
interface issue_if;
    import int_core_pkg::*;

    logic      valid;
    rob_id_t   rob_id;
    phys_reg_t rd_phy;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    alu_op_t   alu_op;
    word_t     imm;
    word_t     pc;
    word_t     rs1_value;
    word_t     rs2_value;

    modport rs (
        output valid, rob_id, rd_phy, op1_sel, op2_sel, alu_op, imm, pc,
        output rs1_value, rs2_value
    );
    modport alu (
        input  valid, rob_id, rd_phy, op1_sel, op2_sel, alu_op, imm, pc,
        input  rs1_value, rs2_value
    );
endinterface

// File: int_rs.sv
`include "int_core_defs.svh"

module int_rs (
    input  logic   clk,
    input  logic   rst,
    dispatch_if.rs dispatch,
    prf_read_if.rs prf,
    cdb_if.listen  cdb [`CDB_WIDTH],
    issue_if.rs    issue
);
    import int_core_pkg::*;

    // local view of the result buses
    logic      bus_valid [`CDB_WIDTH];
    phys_reg_t bus_tag   [`CDB_WIDTH];

    for (genvar k = 0; k < `CDB_WIDTH; k++) begin : g_bus
        assign bus_valid[k] = cdb[k].valid;
        assign bus_tag[k]   = cdb[k].rd_phy;
    end

    //////////////////////////////
    // station entries
    //////////////////////////////

    logic      ent_free    [`RS_DEPTH];
    rob_id_t   ent_rob_id  [`RS_DEPTH];
    phys_reg_t ent_rd_phy  [`RS_DEPTH];
    phys_reg_t ent_rs1_phy [`RS_DEPTH];
    logic      ent_rs1_rdy [`RS_DEPTH];
    phys_reg_t ent_rs2_phy [`RS_DEPTH];
    logic      ent_rs2_rdy [`RS_DEPTH];
    op1_sel_t  ent_op1_sel [`RS_DEPTH];
    op2_sel_t  ent_op2_sel [`RS_DEPTH];
    alu_op_t   ent_alu_op  [`RS_DEPTH];
    word_t     ent_imm     [`RS_DEPTH];
    word_t     ent_pc      [`RS_DEPTH];

    // oldest-first search starts here
    rs_idx_t top;
    rs_idx_t order [`RS_DEPTH];

    logic    rs1_wake [`RS_DEPTH];
    logic    rs2_wake [`RS_DEPTH];
    logic    src_ok   [`RS_DEPTH];
    logic    disp_rs1_hit;
    logic    disp_rs2_hit;

    logic    push_en;
    rs_idx_t push_idx;
    logic    issue_en;
    rs_idx_t issue_idx;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_order
        assign order[i] = top + rs_idx_t'(i);
    end

    // tag match against both buses, stored entries and the incoming uop
    always_comb begin
        disp_rs1_hit = 1'b0;
        disp_rs2_hit = 1'b0;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (bus_valid[k] && bus_tag[k] == dispatch.rs1_phy) disp_rs1_hit = 1'b1;
            if (bus_valid[k] && bus_tag[k] == dispatch.rs2_phy) disp_rs2_hit = 1'b1;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            rs1_wake[i] = 1'b0;
            rs2_wake[i] = 1'b0;
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (bus_valid[k] && bus_tag[k] == ent_rs1_phy[i]) rs1_wake[i] = 1'b1;
                if (bus_valid[k] && bus_tag[k] == ent_rs2_phy[i]) rs2_wake[i] = 1'b1;
            end
            // pc, imm and zero operands need no register
            src_ok[i] = (ent_op1_sel[i] != OP1_RS1 || ent_rs1_rdy[i] || rs1_wake[i]) &&
                        (ent_op2_sel[i] != OP2_RS2 || ent_rs2_rdy[i] || rs2_wake[i]);
        end
    end

    // any free slot means we can take a uop
    always_comb begin
        dispatch.ready = 1'b0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ent_free[i]) dispatch.ready = 1'b1;
        end
    end

    // first free slot at or after top
    always_comb begin
        push_en  = 1'b0;
        push_idx = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!push_en && ent_free[order[i]]) begin
                push_en  = dispatch.valid && dispatch.ready;
                push_idx = order[i];
            end
        end
    end

    // oldest ready entry
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!issue_en && !ent_free[order[i]] && src_ok[order[i]]) begin
                issue_en  = 1'b1;
                issue_idx = order[i];
            end
        end
    end

    // occupancy and top pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                ent_free[i] <= 1'b1;
            end
        end else begin
            if (push_en) ent_free[push_idx] <= 1'b0;
            if (issue_en) begin
                ent_free[issue_idx] <= 1'b1;
                top                 <= issue_idx + rs_idx_t'(1);
            end
        end
    end

    // entry payload and source ready bits
    always_ff @(posedge clk) begin
        if (push_en) begin
            ent_rob_id[push_idx]  <= dispatch.rob_id;
            ent_rd_phy[push_idx]  <= dispatch.rd_phy;
            ent_rs1_phy[push_idx] <= dispatch.rs1_phy;
            ent_rs1_rdy[push_idx] <= dispatch.rs1_valid || disp_rs1_hit;
            ent_rs2_phy[push_idx] <= dispatch.rs2_phy;
            ent_rs2_rdy[push_idx] <= dispatch.rs2_valid || disp_rs2_hit;
            ent_op1_sel[push_idx] <= dispatch.op1_sel;
            ent_op2_sel[push_idx] <= dispatch.op2_sel;
            ent_alu_op[push_idx]  <= dispatch.alu_op;
            ent_imm[push_idx]     <= dispatch.imm;
            ent_pc[push_idx]      <= dispatch.pc;
        end
        // wakeup from either bus
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!ent_free[i] && rs1_wake[i]) ent_rs1_rdy[i] <= 1'b1;
            if (!ent_free[i] && rs2_wake[i]) ent_rs2_rdy[i] <= 1'b1;
        end
    end

    //////////////////////////////
    // issue register
    //////////////////////////////

    assign prf.rs1_phy = ent_rs1_phy[issue_idx];
    assign prf.rs2_phy = ent_rs2_phy[issue_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            issue.rob_id    <= ent_rob_id[issue_idx];
            issue.rd_phy    <= ent_rd_phy[issue_idx];
            issue.op1_sel   <= ent_op1_sel[issue_idx];
            issue.op2_sel   <= ent_op2_sel[issue_idx];
            issue.alu_op    <= ent_alu_op[issue_idx];
            issue.imm       <= ent_imm[issue_idx];
            issue.pc        <= ent_pc[issue_idx];
            issue.rs1_value <= prf.rs1_value;
            issue.rs2_value <= prf.rs2_value;
        end
    end

    // accepted uop always finds a slot and holds it next cycle
    a_no_accept_full: assert property (@(posedge clk) disable iff (rst)
        (dispatch.valid && dispatch.ready) |-> push_en ##1 !ent_free[$past(push_idx)]);

    // issued entry was live, is released and shows up in the issue register
    a_issue_occupied: assert property (@(posedge clk) disable iff (rst)
        issue_en |-> !ent_free[issue_idx] ##1 (issue.valid && ent_free[$past(issue_idx)]));

endmodule

// File: phys_reg_file.sv
`include "int_core_defs.svh"

module phys_reg_file (
    input  logic    clk,
    input  logic    rst,
    prf_read_if.prf rd,
    cdb_if.listen   cdb [`CDB_WIDTH]
);
    import int_core_pkg::*;

    word_t regs [`PHYS_REGS];

    logic      bus_valid [`CDB_WIDTH];
    phys_reg_t bus_tag   [`CDB_WIDTH];
    word_t     bus_value [`CDB_WIDTH];

    for (genvar k = 0; k < `CDB_WIDTH; k++) begin : g_bus
        assign bus_valid[k] = cdb[k].valid;
        assign bus_tag[k]   = cdb[k].rd_phy;
        assign bus_value[k] = cdb[k].value;
    end

    // one write port per bus
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (bus_valid[k]) regs[bus_tag[k]] <= bus_value[k];
            end
        end
    end

    // reads see this cycle's broadcast
    always_comb begin
        rd.rs1_value = regs[rd.rs1_phy];
        rd.rs2_value = regs[rd.rs2_phy];
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (bus_valid[k] && bus_tag[k] == rd.rs1_phy) rd.rs1_value = bus_value[k];
            if (bus_valid[k] && bus_tag[k] == rd.rs2_phy) rd.rs2_value = bus_value[k];
        end
    end

    // alu and external unit must never target the same register together
    a_bus_tag_unique: assert property (@(posedge clk) disable iff (rst)
        (bus_valid[0] && bus_valid[1]) |-> bus_tag[0] != bus_tag[1]);

endmodule

// File: fu_alu.sv
module fu_alu (
    input  logic  clk,
    input  logic  rst,
    issue_if.alu  issue,
    cdb_if.drive  result
);
    import int_core_pkg::*;

    word_t op1;
    word_t op2;
    word_t alu_out;

    //////////////////////////////
    // operand muxes
    //////////////////////////////

    always_comb begin
        case (issue.op1_sel)
            OP1_RS1: op1 = issue.rs1_value;
            OP1_PC:  op1 = issue.pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (issue.op2_sel)
            OP2_RS2: op2 = issue.rs2_value;
            OP2_IMM: op2 = issue.imm;
            default: op2 = '0;
        endcase
    end

    // shifts take the low five bits of op2
    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  alu_out = op1 + op2;
            ALU_SUB:  alu_out = op1 - op2;
            ALU_AND:  alu_out = op1 & op2;
            ALU_OR:   alu_out = op1 | op2;
            ALU_XOR:  alu_out = op1 ^ op2;
            ALU_SLL:  alu_out = op1 << op2[4:0];
            ALU_SRL:  alu_out = op1 >> op2[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op1) >>> op2[4:0]);
            ALU_SLT:  alu_out = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_out = word_t'(op1 < op2);
            default:  alu_out = '0;
        endcase
    end

    //////////////////////////////
    // bus 0 output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result.rob_id <= issue.rob_id;
            result.rd_phy <= issue.rd_phy;
            result.value  <= alu_out;
        end
    end

    // single-cycle latency from the issue register
    a_result_follows_issue: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> $past(issue.valid));

endmodule

// File: int_core.sv
`include "int_core_defs.svh"

module int_core (
    input  logic                   clk,
    input  logic                   rst,

    // dispatch port
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  int_core_pkg::rob_id_t  disp_rob_id,
    input  int_core_pkg::phys_reg_t disp_rd_phy,
    input  int_core_pkg::phys_reg_t disp_rs1_phy,
    input  logic                   disp_rs1_valid,
    input  int_core_pkg::phys_reg_t disp_rs2_phy,
    input  logic                   disp_rs2_valid,
    input  int_core_pkg::op1_sel_t disp_op1_sel,
    input  int_core_pkg::op2_sel_t disp_op2_sel,
    input  int_core_pkg::alu_op_t  disp_alu_op,
    input  int_core_pkg::word_t    disp_imm,
    input  int_core_pkg::word_t    disp_pc,

    // external result, stands in for a load unit
    input  logic                   ext_valid,
    input  int_core_pkg::phys_reg_t ext_rd_phy,
    input  int_core_pkg::word_t    ext_value,

    // alu result bus
    output logic                   res_valid,
    output int_core_pkg::rob_id_t  res_rob_id,
    output int_core_pkg::phys_reg_t res_rd_phy,
    output int_core_pkg::word_t    res_value
);

    dispatch_if disp ();
    prf_read_if prf_rd ();
    issue_if    iss ();
    cdb_if      cdb_bus [`CDB_WIDTH] ();

    //////////////////////////////
    // port mapping
    //////////////////////////////

    assign disp.valid     = disp_valid;
    assign disp.rob_id    = disp_rob_id;
    assign disp.rd_phy    = disp_rd_phy;
    assign disp.rs1_phy   = disp_rs1_phy;
    assign disp.rs1_valid = disp_rs1_valid;
    assign disp.rs2_phy   = disp_rs2_phy;
    assign disp.rs2_valid = disp_rs2_valid;
    assign disp.op1_sel   = disp_op1_sel;
    assign disp.op2_sel   = disp_op2_sel;
    assign disp.alu_op    = disp_alu_op;
    assign disp.imm       = disp_imm;
    assign disp.pc        = disp_pc;
    assign disp_ready     = disp.ready;

    // bus 1 has no rob tag
    assign cdb_bus[1].valid  = ext_valid;
    assign cdb_bus[1].rob_id = '0;
    assign cdb_bus[1].rd_phy = ext_rd_phy;
    assign cdb_bus[1].value  = ext_value;

    assign res_valid  = cdb_bus[0].valid;
    assign res_rob_id = cdb_bus[0].rob_id;
    assign res_rd_phy = cdb_bus[0].rd_phy;
    assign res_value  = cdb_bus[0].value;

    int_rs u_rs (
        .clk      (clk),
        .rst      (rst),
        .dispatch (disp),
        .prf      (prf_rd),
        .cdb      (cdb_bus),
        .issue    (iss)
    );

    phys_reg_file u_prf (
        .clk (clk),
        .rst (rst),
        .rd  (prf_rd),
        .cdb (cdb_bus)
    );

    fu_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (iss),
        .result (cdb_bus[0])
    );

endmodule

// File: int_core_tb.sv
`include "int_core_defs.svh"

module int_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import int_core_pkg::*;

    localparam int        TIMEOUT  = 100;
    localparam int        MAX_ROWS = 32;
    localparam phys_reg_t BLK_TAG  = 6'd50;
    localparam word_t     BLK_VAL  = 32'h0000_0a50;

    logic      clk;
    logic      rst;
    logic      disp_valid;
    logic      disp_ready;
    rob_id_t   disp_rob_id;
    phys_reg_t disp_rd_phy;
    phys_reg_t disp_rs1_phy;
    logic      disp_rs1_valid;
    phys_reg_t disp_rs2_phy;
    logic      disp_rs2_valid;
    op1_sel_t  disp_op1_sel;
    op2_sel_t  disp_op2_sel;
    alu_op_t   disp_alu_op;
    word_t     disp_imm;
    word_t     disp_pc;
    logic      ext_valid;
    phys_reg_t ext_rd_phy;
    word_t     ext_value;
    logic      res_valid;
    rob_id_t   res_rob_id;
    phys_reg_t res_rd_phy;
    word_t     res_value;

    //////////////////////////////
    // stimulus table indexed by rob id
    //////////////////////////////

    phys_reg_t row_rd      [MAX_ROWS];
    phys_reg_t row_rs1     [MAX_ROWS];
    logic      row_rs1_rdy [MAX_ROWS];
    phys_reg_t row_rs2     [MAX_ROWS];
    logic      row_rs2_rdy [MAX_ROWS];
    op1_sel_t  row_op1     [MAX_ROWS];
    op2_sel_t  row_op2     [MAX_ROWS];
    alu_op_t   row_op      [MAX_ROWS];
    word_t     row_imm     [MAX_ROWS];
    word_t     row_pc      [MAX_ROWS];
    logic      row_ext     [MAX_ROWS];
    phys_reg_t row_ext_tag [MAX_ROWS];
    word_t     row_ext_val [MAX_ROWS];
    word_t     row_exp     [MAX_ROWS];
    int        n_rows;

    // reference register state
    word_t ref_regs [`PHYS_REGS];

    logic pending    [MAX_ROWS];
    logic done       [MAX_ROWS];
    int   accept_cyc [MAX_ROWS];
    int   done_cyc   [MAX_ROWS];
    int   ext_cyc;
    int   cycle;
    int   errors;
    int   checks;
    int   seed;

    int_core uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        word_t  r;
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            // fill vacated upper bits with the sign
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            default:  r = 32'd0;
        endcase
        return r;
    endfunction

    task automatic add_row(
        input phys_reg_t rd, input phys_reg_t rs1, input logic rs1_rdy,
        input phys_reg_t rs2, input logic rs2_rdy,
        input op1_sel_t op1, input op2_sel_t op2, input alu_op_t op,
        input word_t imm, input word_t pc,
        input logic ext, input phys_reg_t ext_tag, input word_t ext_val
    );
        word_t a;
        word_t b;
        int    r;
        r = n_rows;
        // the op waits for its external operand
        if (ext) ref_regs[ext_tag] = ext_val;
        case (op1)
            OP1_RS1: a = ref_regs[rs1];
            OP1_PC:  a = pc;
            default: a = 32'd0;
        endcase
        case (op2)
            OP2_RS2: b = ref_regs[rs2];
            OP2_IMM: b = imm;
            default: b = 32'd0;
        endcase
        row_rd[r]      = rd;
        row_rs1[r]     = rs1;
        row_rs1_rdy[r] = rs1_rdy;
        row_rs2[r]     = rs2;
        row_rs2_rdy[r] = rs2_rdy;
        row_op1[r]     = op1;
        row_op2[r]     = op2;
        row_op[r]      = op;
        row_imm[r]     = imm;
        row_pc[r]      = pc;
        row_ext[r]     = ext;
        row_ext_tag[r] = ext_tag;
        row_ext_val[r] = ext_val;
        row_exp[r]     = alu_model(op, a, b);
        ref_regs[rd]   = row_exp[r];
        n_rows++;
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // entered just after a falling edge
    task automatic dispatch_row(input int i);
        int   n;
        logic ok;
        n = 0;
        disp_valid     = 1'b1;
        disp_rob_id    = rob_id_t'(i);
        disp_rd_phy    = row_rd[i];
        disp_rs1_phy   = row_rs1[i];
        disp_rs1_valid = row_rs1_rdy[i];
        disp_rs2_phy   = row_rs2[i];
        disp_rs2_valid = row_rs2_rdy[i];
        disp_op1_sel   = row_op1[i];
        disp_op2_sel   = row_op2[i];
        disp_alu_op    = row_op[i];
        disp_imm       = row_imm[i];
        disp_pc        = row_pc[i];
        while (!disp_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = disp_ready;
        assert (ok) else begin
            $display("timeout waiting for disp_ready on row %0d", i);
            errors++;
        end
        @(negedge clk);
        disp_valid = 1'b0;
        if (ok) begin
            pending[i]    = 1'b1;
            accept_cyc[i] = cycle;
        end
    endtask

    task automatic drive_ext(input phys_reg_t tag, input word_t value);
        ext_valid  = 1'b1;
        ext_rd_phy = tag;
        ext_value  = value;
        ext_cyc    = cycle;
        @(negedge clk);
        ext_valid  = 1'b0;
    endtask

    task automatic wait_done(input int i);
        int n;
        n = 0;
        while (!done[i] && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (done[i]) else begin
            $display("timeout waiting for the result of rob id %0d", i);
            errors++;
        end
    endtask

    task automatic apply_row(input int i);
        dispatch_row(i);
        if (row_ext[i]) begin
            repeat (4) @(negedge clk);
            assert (!done[i]) else begin
                $display("rob id %0d completed before its external operand arrived", i);
                errors++;
            end
            drive_ext(row_ext_tag[i], row_ext_val[i]);
        end
        wait_done(i);
    endtask

    // result monitor matches by rob id
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            assert (pending[res_rob_id]) else begin
                $display("result for rob id %0d arrived but none was outstanding", res_rob_id);
                errors++;
            end
            if (pending[res_rob_id]) begin
                check_value("res_value", row_exp[res_rob_id], res_value);
                check_value("res_rd_phy", word_t'(row_rd[res_rob_id]), word_t'(res_rd_phy));
                pending[res_rob_id]  = 1'b0;
                done[res_rob_id]     = 1'b1;
                done_cyc[res_rob_id] = cycle;
            end
        end
    end

    initial begin
        int        j;
        phys_reg_t rs1;
        alu_op_t   op;
        clk = 1'b0;
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_rob_id = '0;
        disp_rd_phy = '0;
        disp_rs1_phy = '0;
        disp_rs1_valid = 1'b0;
        disp_rs2_phy = '0;
        disp_rs2_valid = 1'b0;
        disp_op1_sel = OP1_RS1;
        disp_op2_sel = OP2_RS2;
        disp_alu_op = ALU_ADD;
        disp_imm = '0;
        disp_pc = '0;
        ext_valid = 1'b0;
        ext_rd_phy = '0;
        ext_value = '0;
        cycle = 0;
        errors = 0;
        checks = 0;
        n_rows = 0;
        ext_cyc = 0;
        seed = 32'he6d2;
        for (j = 0; j < MAX_ROWS; j++) begin
            pending[j] = 1'b0;
            done[j] = 1'b0;
            accept_cyc[j] = 0;
            done_cyc[j] = 0;
        end
        for (j = 0; j < `PHYS_REGS; j++) ref_regs[j] = 32'd0;

        //////////////////////////////
        // table build
        //////////////////////////////

        // rows 0-3 need no register operands
        add_row(6'd1, 6'd0, 1'b1, 6'd0, 1'b1, OP1_PC, OP2_IMM, ALU_ADD,
                32'h24, 32'h1000, 1'b0, 6'd0, 32'd0);
        add_row(6'd2, 6'd0, 1'b1, 6'd0, 1'b1, OP1_ZERO, OP2_IMM, ALU_SUB,
                32'h5, 32'd0, 1'b0, 6'd0, 32'd0);
        add_row(6'd3, 6'd0, 1'b1, 6'd0, 1'b1, OP1_PC, OP2_ZERO, ALU_OR,
                32'd0, 32'hdead_0000, 1'b0, 6'd0, 32'd0);
        add_row(6'd4, 6'd0, 1'b1, 6'd0, 1'b1, OP1_PC, OP2_IMM, ALU_SRA,
                32'h4, 32'h8000_0000, 1'b0, 6'd0, 32'd0);
        // rows 4-7 chain through alu results
        add_row(6'd5, 6'd1, 1'b1, 6'd0, 1'b1, OP1_RS1, OP2_IMM, ALU_ADD,
                32'h1, 32'd0, 1'b0, 6'd0, 32'd0);
        add_row(6'd6, 6'd5, 1'b0, 6'd0, 1'b1, OP1_RS1, OP2_IMM, ALU_SLL,
                32'h2, 32'd0, 1'b0, 6'd0, 32'd0);
        add_row(6'd7, 6'd6, 1'b0, 6'd0, 1'b1, OP1_RS1, OP2_IMM, ALU_XOR,
                32'hff, 32'd0, 1'b0, 6'd0, 32'd0);
        add_row(6'd8, 6'd7, 1'b0, 6'd0, 1'b1, OP1_RS1, OP2_IMM, ALU_SUB,
                32'h3, 32'd0, 1'b0, 6'd0, 32'd0);
        // rows 8-9 wait on the external bus
        add_row(6'd9, 6'd2, 1'b1, 6'd40, 1'b0, OP1_RS1, OP2_RS2, ALU_SUB,
                32'd0, 32'd0, 1'b1, 6'd40, 32'h100);
        add_row(6'd10, 6'd41, 1'b0, 6'd0, 1'b1, OP1_RS1, OP2_IMM, ALU_XOR,
                32'h5a5a, 32'd0, 1'b1, 6'd41, 32'hcafe_f00d);
        // rows 10-17 fill the station and row 18 is held
        ref_regs[BLK_TAG] = BLK_VAL;
        for (j = 0; j < 8; j++) begin
            add_row(phys_reg_t'(11 + j), BLK_TAG, 1'b0, 6'd0, 1'b1, OP1_RS1, OP2_IMM,
                    alu_op_t'(4'(j)), word_t'(j + 1), 32'd0, 1'b0, 6'd0, 32'd0);
        end
        add_row(6'd19, 6'd0, 1'b1, 6'd0, 1'b1, OP1_ZERO, OP2_IMM, ALU_ADD,
                32'h99, 32'd0, 1'b0, 6'd0, 32'd0);
        // rows 19-30 random with every alu op at least once
        for (j = 0; j < 12; j++) begin
            rs1 = phys_reg_t'($unsigned($random(seed)) % (20 + j));
            if (j < 10) op = alu_op_t'(4'(j));
            else        op = alu_op_t'(4'($unsigned($random(seed)) % 10));
            add_row(phys_reg_t'(20 + j), rs1, 1'b1, phys_reg_t'(52 + j), 1'b0,
                    OP1_RS1, OP2_RS2, op, 32'd0, 32'd0,
                    1'b1, phys_reg_t'(52 + j), word_t'($random(seed)));
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("res_valid", 32'd0, word_t'(res_valid));
        check_value("disp_ready", 32'd1, word_t'(disp_ready));

        // lone ready op returns two edges after accept
        for (j = 0; j < 4; j++) begin
            apply_row(j);
            check_value("result latency", 32'd2, word_t'(done_cyc[j] - accept_cyc[j]));
        end

        for (j = 4; j < 8; j++) dispatch_row(j);
        for (j = 4; j < 8; j++) wait_done(j);
        // each dependant issues in the cycle its producer broadcasts
        for (j = 5; j < 8; j++) begin
            check_value("chain result spacing", 32'd2,
                        word_t'(done_cyc[j] - done_cyc[j - 1]));
        end

        for (j = 8; j < 10; j++) apply_row(j);

        ////////////////////////////// full station
        for (j = 10; j < 18; j++) dispatch_row(j);
        check_value("disp_ready", 32'd0, word_t'(disp_ready));
        fork
            dispatch_row(18);
            begin
                repeat (4) @(negedge clk);
                check_value("disp_ready", 32'd0, word_t'(disp_ready));
                drive_ext(BLK_TAG, BLK_VAL);
            end
        join
        assert (accept_cyc[18] > ext_cyc) else begin
            $display("held op was accepted before the station freed an entry");
            errors++;
        end
        for (j = 10; j < 19; j++) wait_done(j);

        for (j = 19; j < n_rows; j++) apply_row(j);

        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: int_core.f
+incdir+.
int_core_pkg.sv
int_core_if.sv
int_rs.sv
phys_reg_file.sv
fu_alu.sv
int_core.sv
int_core_tb.sv

// File: Makefile
TB := int_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f int_core.f --top-module $(TB)

# pass or fail comes from the log
run: build
	./obj_dir/V$(TB) | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -f int_core.f --top-module int_core

clean:
	rm -rf obj_dir sim.log
